//--- project.f
hw/quant_pkg.sv
hw/quant_table.sv
hw/coef_conditioner.sv
hw/quant_multiplier.sv
hw/zigzag_reorder.sv
hw/jpeg_quantizer.sv
testbench/tb_jpeg_quantizer.sv

//--- Bender.yml
package:
  name: jpeg_quantizer

sources:
  - files:
      - hw/quant_pkg.sv
      - hw/quant_table.sv
      - hw/coef_conditioner.sv
      - hw/quant_multiplier.sv
      - hw/zigzag_reorder.sv
      - hw/jpeg_quantizer.sv
  - target: test
    files:
      - testbench/tb_jpeg_quantizer.sv

//--- testbench/tb_jpeg_quantizer.sv
/*
 * testbench for the JPEG quantizer stage
 * APB table load and readback, block stream from a stimulus table
 * reference quantizer and zigzag order, output timing checks
 */

`timescale 1ns/1ps

module tb_jpeg_quantizer;

    localparam int CLK_PERIOD = 8;
    localparam int APB_TMO    = 10;                 // cycles per APB transfer
    localparam int OUT_TMO    = 300;                // cycles to first output word
    localparam int NUM_BLK    = 7;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [9:0]  paddr;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        pready;
    logic        start;
    logic signed [12:0] coef;
    logic signed [8:0]  dc;
    logic [2:0]  tsel;
    logic        ctype;
    logic signed [12:0] out_data;
    logic        out_valid;
    logic        out_start;

    int seed = 32'h767b99d1;
    int cyc = 0;                                     // posedge count
    int tbl [0:1023];                                // model of all 16 tables
    int exp_q[$];                                    // expected words, zigzag order
    int t0_q[$];                                     // start cycle of each block

    // standard JPEG scan, natural position of zigzag word m
    int zz [0:63] = '{0, 1, 8, 16, 9, 2, 3, 10, 17, 24, 32, 25, 18, 11, 4, 5,
                      12, 19, 26, 33, 40, 48, 41, 34, 27, 20, 13, 6, 7, 14, 21, 28,
                      35, 42, 49, 56, 57, 50, 43, 36, 29, 22, 15, 23, 30, 37, 44, 51,
                      58, 59, 52, 45, 38, 31, 39, 46, 53, 60, 61, 54, 47, 55, 62, 63};

    // stimulus table, kind 0 zeros, 1 ramp, 2 rounding edges, 3 random
    string blk_name [0:NUM_BLK-1] = '{"dc_only", "unity_ramp", "small_recip", "half_recip",
                                      "rand_t0_luma", "rand_t3_chroma", "rand_t7_chroma"};
    int blk_tsel   [0:NUM_BLK-1] = '{5, 5, 6, 5, 0, 3, 7};
    int blk_ctype  [0:NUM_BLK-1] = '{1, 0, 0, 1, 0, 1, 1};
    int blk_dc     [0:NUM_BLK-1] = '{-100, 3, 0, -1, 12, -255, 200};
    int blk_kind   [0:NUM_BLK-1] = '{0, 1, 2, 2, 3, 3, 3};
    int blk_corner [0:NUM_BLK-1] = '{-400, 24, 0, 2044, 0, 0, 0};   // word 0 by hand
    bit blk_has_c  [0:NUM_BLK-1] = '{1, 1, 1, 1, 0, 0, 0};

    jpeg_quantizer #(
        .NUM_TABLES (8)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .start     (start),
        .coef      (coef),
        .dc        (dc),
        .tsel      (tsel),
        .ctype     (ctype),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_start (out_start)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input string name, input logic signed [31:0] expected,
                         input logic signed [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %0d actual %0d", name, expected, actual);
            stop_with_fail("check failed");
        end
    endtask

    // one APB transfer, returns wait cycles seen in the access phase
    task automatic apb_xfer(input bit wr, input int addr, input int wdata,
                            output logic [31:0] rdata, output int waits);
        int n;
        n = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr[9:0];
        pwdata  = wdata[15:0];
        @(negedge clk);
        penable = 1'b1;
        while (!pready) begin
            @(negedge clk);
            n++;
            if (n > APB_TMO) stop_with_fail("APB transfer never got pready");
        end
        rdata = prdata;
        waits = n;
        @(negedge clk);                              // access completed on last posedge
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input int addr, input int data);
        logic [31:0] rd;
        int w;
        apb_xfer(1'b1, addr, data, rd, w);
        check("apb write waits", 0, w);
        tbl[addr] = data;
    endtask

    task automatic apb_read_check(input int addr);
        logic [31:0] rd;
        int w;
        apb_xfer(1'b0, addr, 0, rd, w);
        check("apb read waits", 1, w);
        check($sformatf("readback %0d", addr), tbl[addr], rd);
    endtask

    // sign(x) * ((|x| * r + half) >> 16), zero stays positive
    function automatic int quantize(input int x, input int r);
        int a;
        int m;
        a = (x < 0) ? -x : x;
        m = (a * r + 32768) >>> 16;
        return (x < 0) ? -m : m;
    endfunction

    function automatic int make_coef(input int kind, input int k);
        case (kind)
            0: return 0;
            1: return (k % 2) ? -(k * 61) : k * 61;
            2: return (k % 2) ? -(k * 37) : 4095 - k;
            default: return (k == 0) ? $random(seed) % 2001 : $random(seed) % 4096;
        endcase
    endfunction

    task automatic drive_blocks();
        int c;
        int x;
        int base;
        int nat [0:63];
        for (int b = 0; b < NUM_BLK; b++) begin
            base = blk_tsel[b] * 128 + blk_ctype[b] * 64;
            for (int k = 0; k < 64; k++) begin
                c = make_coef(blk_kind[b], k);
                x = (k == 0) ? c + blk_dc[b] * 8 : c;         // dc only on coef 0
                nat[k] = quantize(x, tbl[base + k]);
                @(negedge clk);
                start = (k == 0);
                coef  = c;
                if (k == 0) begin
                    dc    = blk_dc[b];
                    tsel  = blk_tsel[b];
                    ctype = blk_ctype[b];
                    t0_q.push_back(cyc);
                end
            end
            for (int m = 0; m < 64; m++) exp_q.push_back(nat[zz[m]]);
        end
        @(negedge clk);
        start = 1'b0;
        coef  = '0;
    endtask

    task automatic collect_blocks();
        int n;
        int t0;
        for (int b = 0; b < NUM_BLK; b++) begin
            n = 0;
            while (!out_start) begin
                @(negedge clk);
                n++;
                if (n > OUT_TMO) stop_with_fail("no output block appeared");
            end
            t0 = t0_q.pop_front();
            check({blk_name[b], " out_start cycle"}, t0 + 69, cyc);
            if (blk_has_c[b]) check({blk_name[b], " corner"}, blk_corner[b], out_data);
            for (int m = 0; m < 64; m++) begin
                check({blk_name[b], " out_valid"}, 1, out_valid);
                check({blk_name[b], " out_start"}, (m == 0), out_start);
                check($sformatf("%s word %0d", blk_name[b], m), exp_q.pop_front(),
                      out_data);
                @(negedge clk);
            end
        end
        check("out_valid after last block", 0, out_valid);
    endtask

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        start   = 1'b0;
        coef    = '0;
        dc      = '0;
        tsel    = '0;
        ctype   = 1'b0;
        rst     = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("out_valid after reset", 0, out_valid);
        check("out_start after reset", 0, out_start);
        check("pready after reset", 0, pready);

        // all 16 tables random, then read back
        for (int a = 0; a < 1024; a++) apb_write(a, $random(seed) & 16'hffff);
        for (int a = 0; a < 1024; a++) apb_read_check(a);

        // fixed tables for the rounding cases
        for (int k = 0; k < 64; k++) begin
            apb_write(5 * 128 + k, 65535);
            apb_write(5 * 128 + 64 + k, 32768);
            apb_write(6 * 128 + k, k + 1);
        end
        apb_read_check(5 * 128 + 63);
        apb_read_check(6 * 128);

        fork
            drive_blocks();
            collect_blocks();
        join

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- hw/jpeg_quantizer.sv
/*
 * JPEG quantizer stage top
 * table lookup and coefficient path side by side, multiplier, zigzag buffer
 */

`timescale 1ns/1ps

module jpeg_quantizer #(
    parameter int NUM_TABLES = 8
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        psel,
    input  logic                                        penable,
    input  logic                                        pwrite,
    input  logic [quant_pkg::TSEL_W+quant_pkg::IDX_W:0] paddr,
    input  logic [quant_pkg::QT_W-1:0]                  pwdata,
    output logic [quant_pkg::QT_W-1:0]                  prdata,
    output logic                                        pready,
    input  logic                                        start,
    input  logic signed [quant_pkg::COEF_W-1:0]         coef,
    input  logic signed [quant_pkg::DC_W-1:0]           dc,
    input  logic [quant_pkg::TSEL_W-1:0]                tsel,
    input  logic                                        ctype,
    output logic signed [quant_pkg::COEF_W-1:0]         out_data,
    output logic                                        out_valid,
    output logic                                        out_start
);

    logic        [quant_pkg::MAG_W-1:0]  mag;                      // t0+k+2
    logic                                neg;
    logic        [quant_pkg::QT_W-1:0]   recip;                    // t0+k+2
    logic        [quant_pkg::IDX_W-1:0]  idx;
    logic                                tbl_valid;
    logic signed [quant_pkg::COEF_W-1:0] q;                        // t0+k+4
    logic        [quant_pkg::IDX_W-1:0]  q_idx;
    logic                                q_valid;

    quant_table #(
        .NUM_TABLES (NUM_TABLES)
    ) quant_table_i (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .start     (start),
        .tsel      (tsel),
        .ctype     (ctype),
        .recip     (recip),
        .idx       (idx),
        .tbl_valid (tbl_valid)
    );

    coef_conditioner coef_conditioner_i (
        .clk   (clk),
        .start (start),
        .coef  (coef),
        .dc    (dc),
        .mag   (mag),
        .neg   (neg)
    );

    quant_multiplier quant_multiplier_i (
        .clk       (clk),
        .rst       (rst),
        .mag       (mag),
        .neg       (neg),
        .recip     (recip),
        .idx       (idx),
        .tbl_valid (tbl_valid),
        .q         (q),
        .q_idx     (q_idx),
        .q_valid   (q_valid)
    );

    zigzag_reorder zigzag_reorder_i (
        .clk       (clk),
        .rst       (rst),
        .q         (q),
        .q_idx     (q_idx),
        .q_valid   (q_valid),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_start (out_start)
    );

endmodule

//--- hw/zigzag_reorder.sv
/*
 * ping-pong block buffer, natural order in, zigzag order out
 * half-size zigzag scan ROM mirrored by complement
 */

`timescale 1ns/1ps

module zigzag_reorder (
    input  logic                                clk,
    input  logic                                rst,
    input  logic signed [quant_pkg::COEF_W-1:0] q,
    input  logic        [quant_pkg::IDX_W-1:0]  q_idx,
    input  logic                                q_valid,
    output logic signed [quant_pkg::COEF_W-1:0] out_data,
    output logic                                out_valid,
    output logic                                out_start
);

    localparam logic [quant_pkg::IDX_W-1:0] LAST_IDX = quant_pkg::IDX_W'(quant_pkg::BLOCK_SIZE - 1);

    logic signed [quant_pkg::COEF_W-1:0] buf_mem [0:2*quant_pkg::BLOCK_SIZE-1];

    logic                         wpage;                          // page being filled
    logic                         rpage;                          // page being scanned
    logic                         wr_last;
    logic                         rd_en;
    logic [quant_pkg::IDX_W-1:0]  rd_cnt;                         // zigzag position m
    logic [quant_pkg::IDX_W-2:0]  rom_a;
    logic [quant_pkg::IDX_W-1:0]  rom_q;
    logic [quant_pkg::IDX_W-1:0]  zz_addr;                        // natural position

    assign wr_last = q_valid && (q_idx == LAST_IDX);

    // scan is point symmetric, second half = 63 - first half reversed
    assign rom_a   = rd_cnt[quant_pkg::IDX_W-1] ? ~rd_cnt[quant_pkg::IDX_W-2:0]
                                                :  rd_cnt[quant_pkg::IDX_W-2:0];
    assign zz_addr = rd_cnt[quant_pkg::IDX_W-1] ? ~rom_q : rom_q;

    always_comb begin
        case (rom_a)
            5'h00: rom_q = 6'd0;
            5'h01: rom_q = 6'd1;
            5'h02: rom_q = 6'd8;
            5'h03: rom_q = 6'd16;
            5'h04: rom_q = 6'd9;
            5'h05: rom_q = 6'd2;
            5'h06: rom_q = 6'd3;
            5'h07: rom_q = 6'd10;
            5'h08: rom_q = 6'd17;
            5'h09: rom_q = 6'd24;
            5'h0a: rom_q = 6'd32;
            5'h0b: rom_q = 6'd25;
            5'h0c: rom_q = 6'd18;
            5'h0d: rom_q = 6'd11;
            5'h0e: rom_q = 6'd4;
            5'h0f: rom_q = 6'd5;
            5'h10: rom_q = 6'd12;
            5'h11: rom_q = 6'd19;
            5'h12: rom_q = 6'd26;
            5'h13: rom_q = 6'd33;
            5'h14: rom_q = 6'd40;
            5'h15: rom_q = 6'd48;
            5'h16: rom_q = 6'd41;
            5'h17: rom_q = 6'd34;
            5'h18: rom_q = 6'd27;
            5'h19: rom_q = 6'd20;
            5'h1a: rom_q = 6'd13;
            5'h1b: rom_q = 6'd6;
            5'h1c: rom_q = 6'd7;
            5'h1d: rom_q = 6'd14;
            5'h1e: rom_q = 6'd21;
            default: rom_q = 6'd28;                                // 5'h1f
        endcase
    end

    always_ff @(posedge clk) begin
        if (q_valid) buf_mem[{wpage, q_idx}] <= q;                 // natural order
        if (rd_en) out_data <= buf_mem[{rpage, zz_addr}];          // data one cycle later
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wpage     <= 1'b0;
            rpage     <= 1'b0;
            rd_en     <= 1'b0;
            rd_cnt    <= '0;
            out_valid <= 1'b0;
            out_start <= 1'b0;
        end else begin
            if (wr_last) begin
                wpage  <= ~wpage;                                  // next block to other page
                rpage  <= wpage;
                rd_en  <= 1'b1;
                rd_cnt <= '0;
            end else if (rd_en) begin
                rd_en  <= (rd_cnt != LAST_IDX);
                rd_cnt <= rd_cnt + 1'b1;
            end
            out_valid <= rd_en;
            out_start <= rd_en && (rd_cnt == '0);                  // first word, t0+69
        end
    end

    // a full block must not arrive before the previous scan reached its end
    a_no_rd_overlap: assert property (@(posedge clk) disable iff (rst)
        wr_last |-> (!rd_en || (rd_cnt == LAST_IDX)));

endmodule

//--- hw/quant_multiplier.sv
/*
 * magnitude times reciprocal, rounding, sign restore
 * index and valid delayed along with the data
 */

`timescale 1ns/1ps

module quant_multiplier (
    input  logic                                clk,
    input  logic                                rst,
    input  logic        [quant_pkg::MAG_W-1:0]  mag,
    input  logic                                neg,
    input  logic        [quant_pkg::QT_W-1:0]   recip,
    input  logic        [quant_pkg::IDX_W-1:0]  idx,
    input  logic                                tbl_valid,
    output logic signed [quant_pkg::COEF_W-1:0] q,
    output logic        [quant_pkg::IDX_W-1:0]  q_idx,
    output logic                                q_valid
);

    localparam int PROD_W = quant_pkg::MAG_W + quant_pkg::QT_W;   // 28 bit product
    localparam int unsigned HALF = 1 << (quant_pkg::ROUND_SHIFT - 1);

    logic [PROD_W-1:0]            prod;                           // stage A
    logic                         neg_a;
    logic [quant_pkg::IDX_W-1:0]  idx_a;
    logic                         valid_a;
    logic [PROD_W:0]              rnd_sum;
    logic [quant_pkg::COEF_W-1:0] rnd_mag;

    always_ff @(posedge clk) begin
        prod  <= mag * recip;
        neg_a <= neg;
        idx_a <= idx;
    end

    assign rnd_sum = {1'b0, prod} + HALF[PROD_W:0];               // add half LSB
    assign rnd_mag = rnd_sum[quant_pkg::ROUND_SHIFT +: quant_pkg::COEF_W];

    always_ff @(posedge clk) begin
        if (neg_a && (rnd_mag != '0)) begin
            q <= -rnd_mag;                                         // sign back on
        end else begin
            q <= rnd_mag;                                          // zero stays positive
        end
        q_idx <= idx_a;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_a <= 1'b0;
            q_valid <= 1'b0;
        end else begin
            valid_a <= tbl_valid;
            q_valid <= valid_a;                                    // t0+k+4
        end
    end

endmodule

//--- hw/coef_conditioner.sv
/*
 * DC restore on coefficient 0, sign/magnitude split
 * two register stages
 */

`timescale 1ns/1ps

module coef_conditioner (
    input  logic                                clk,
    input  logic                                start,   // coefficient 0 here
    input  logic signed [quant_pkg::COEF_W-1:0] coef,
    input  logic signed [quant_pkg::DC_W-1:0]   dc,
    output logic        [quant_pkg::MAG_W-1:0]  mag,
    output logic                                neg
);

    localparam int SUM_W   = quant_pkg::COEF_W + 1;                // headroom for the DC add
    localparam int MAG_MAX = (1 << quant_pkg::MAG_W) - 1;

    logic signed [SUM_W-1:0] coef_ext;
    logic signed [SUM_W-1:0] dc_term;
    logic signed [SUM_W-1:0] sum_s1;                               // stage 1
    logic        [SUM_W-1:0] sum_abs;

    assign coef_ext = {coef[quant_pkg::COEF_W-1], coef};
    assign dc_term  = {{(SUM_W - quant_pkg::DC_W - quant_pkg::DC_SHIFT){dc[quant_pkg::DC_W-1]}},
                       dc, {quant_pkg::DC_SHIFT{1'b0}}};          // dc * 8, sign kept

    always_ff @(posedge clk) begin
        sum_s1 <= coef_ext + (start ? dc_term : {SUM_W{1'b0}});   // only on coef 0
    end

    assign sum_abs = sum_s1[SUM_W-1] ? -sum_s1 : sum_s1;

    always_ff @(posedge clk) begin
        neg <= sum_s1[SUM_W-1];
        mag <= sum_abs[quant_pkg::MAG_W-1:0];                     // upper bits zero by range
    end

    // restored coefficient must fit the 12 bit magnitude path
    a_sum_range: assert property (@(posedge clk)
        !$isunknown(sum_s1) |-> ((sum_s1 >= -MAG_MAX) && (sum_s1 <= MAG_MAX)));

endmodule

//--- hw/quant_table.sv
/*
 * reciprocal quantization tables, APB written and read back
 * per-block lookup counter, one entry per coefficient
 */

`timescale 1ns/1ps

module quant_table #(
    parameter int NUM_TABLES = 8                                   // power of two, up to 8
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        psel,
    input  logic                                        penable,
    input  logic                                        pwrite,
    input  logic [quant_pkg::TSEL_W+quant_pkg::IDX_W:0] paddr,    // {tsel, ctype, idx}
    input  logic [quant_pkg::QT_W-1:0]                  pwdata,
    output logic [quant_pkg::QT_W-1:0]                  prdata,
    output logic                                        pready,
    input  logic                                        start,    // coefficient 0 of a block
    input  logic [quant_pkg::TSEL_W-1:0]                tsel,
    input  logic                                        ctype,    // luma/chroma
    output logic [quant_pkg::QT_W-1:0]                  recip,
    output logic [quant_pkg::IDX_W-1:0]                 idx,
    output logic                                        tbl_valid
);

    localparam int SEL_W  = (NUM_TABLES > 1) ? $clog2(NUM_TABLES) : 1;
    localparam int ADDR_W = SEL_W + 1 + quant_pkg::IDX_W;          // {sel, ctype, idx}
    localparam logic [quant_pkg::IDX_W-1:0] LAST_IDX = quant_pkg::IDX_W'(quant_pkg::BLOCK_SIZE - 1);

    logic [quant_pkg::QT_W-1:0]  tbl_mem [0:(1 << ADDR_W)-1];     // all tables, one array

    quant_pkg::apb_state_e       apb_state;
    logic                        apb_wr;
    logic                        apb_rd;
    logic [ADDR_W-1:0]           apb_addr;

    logic                        lk_run;                           // lookup counter active
    logic [quant_pkg::IDX_W-1:0] lk_idx;
    logic [SEL_W-1:0]            lk_sel;                           // tsel sampled at start
    logic                        lk_ctype;
    logic [ADDR_W-1:0]           lk_addr;

    // APB side, upper select bits alias when fewer tables are built
    assign apb_addr = {paddr[quant_pkg::IDX_W+1 +: SEL_W], paddr[quant_pkg::IDX_W:0]};
    assign apb_wr   = psel && penable && pwrite;                   // done in first access cycle
    assign apb_rd   = psel && penable && !pwrite && (apb_state == quant_pkg::APB_IDLE);
    assign lk_addr  = {lk_sel, lk_ctype, lk_idx};

    always_ff @(posedge clk) begin
        if (rst) begin
            apb_state <= quant_pkg::APB_IDLE;
            pready    <= 1'b0;
        end else begin
            case (apb_state)
                quant_pkg::APB_IDLE: begin
                    pready <= psel && !penable && pwrite;         // write ready in access
                    if (apb_rd) begin
                        apb_state <= quant_pkg::APB_READ_WAIT;
                        pready    <= 1'b1;                        // data lands next cycle
                    end
                end
                default: begin
                    apb_state <= quant_pkg::APB_IDLE;              // read completes here
                    pready    <= 1'b0;
                end
            endcase
        end
    end

    // port A: APB write and read back
    always_ff @(posedge clk) begin
        if (apb_wr) tbl_mem[apb_addr] <= pwdata;
        if (apb_rd) prdata <= tbl_mem[apb_addr];
    end

    // port B: lookup, registered read
    always_ff @(posedge clk) begin
        recip <= tbl_mem[lk_addr];                                 // entry for idx, 1 cycle later
        idx   <= lk_idx;                                           // keep idx next to its entry
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lk_run    <= 1'b0;
            lk_idx    <= '0;
            tbl_valid <= 1'b0;
        end else begin
            if (start) begin
                lk_run <= 1'b1;
                lk_idx <= '0;                                      // restart wins over last
            end else if (lk_run) begin
                lk_run <= (lk_idx != LAST_IDX);
                lk_idx <= lk_idx + 1'b1;
            end
            tbl_valid <= lk_run;                                   // two cycles after coef k
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            lk_sel   <= tsel[SEL_W-1:0];
            lk_ctype <= ctype;
        end
    end

    // a new block may only start once the previous one reached its last index
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        start |-> (!lk_run || (lk_idx == LAST_IDX)));

    // APB access phase must follow a setup phase
    a_apb_setup: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> (psel && $past(psel)));

endmodule

//--- hw/quant_pkg.sv
/*
 * shared widths and sizes of the JPEG quantizer stage
 * APB slave state encoding
 */

package quant_pkg;

    // coefficient path
    localparam int COEF_W      = 13;   // signed DCT coefficient in/out
    localparam int MAG_W       = 12;   // magnitude after sign split
    localparam int DC_W        = 9;    // signed block DC offset
    localparam int DC_SHIFT    = 3;    // DC scaled up before restore

    // quantization tables
    localparam int QT_W        = 16;   // reciprocal, 0.16 fixed point
    localparam int TSEL_W      = 3;    // quality table select
    localparam int ROUND_SHIFT = 16;   // product back to integer

    // block geometry
    localparam int BLOCK_SIZE  = 64;   // 8x8 coefficients
    localparam int IDX_W       = 6;    // index inside a block

    // APB slave, reads take one wait cycle
    typedef enum logic {
        APB_IDLE,                      // waiting for an access
        APB_READ_WAIT                  // table read in flight
    } apb_state_e;

endpackage
